// ==== rtl/rst_ctrl_config.svh ====
/*
 * Reset controller defaults. RST_SYS_HOLD_CYCLES is short for simulation,
 * and hardware wants 1048575. To override, define RST_CTRL_CONFIG_SVH
 * together with all four macros ahead of the sources. Hold lengths must
 * be at least 1 and fit in RST_TIMER_WIDTH bits.
 */
`ifndef RST_CTRL_CONFIG_SVH
`define RST_CTRL_CONFIG_SVH

// Flash held in reset after the restart ends
// 128 cycles covers the minimum pulse width and reset-to-read time
`define RST_FLASH_HOLD_CYCLES 128

// Extra system hold after flash release, 1048575 on the board
`define RST_SYS_HOLD_CYCLES 300

// Button synchronizer depth
`define RST_SYNC_STAGES 2

// Hold counter width, must cover the longer hold
`define RST_TIMER_WIDTH 20

`endif

// ==== rtl/rst_ctrl_pkg.sv ====
/*
 * Shared types of the reset controller.
 * Counter width follows RST_TIMER_WIDTH from the config header.
 */
package rst_ctrl_pkg;

`include "rst_ctrl_config.svh"

	// Sequencer phases
	// Hold-all keeps everything in reset, flash-up frees only the flash
	typedef enum logic [1:0] {
		SEQ_HOLD_ALL = 2'd0,
		SEQ_FLASH_UP = 2'd1,
		SEQ_RUN      = 2'd2
	} seq_state_t;

	// Three user buttons, pressed is 1
	typedef logic [2:0] btn_t;

	// Hold timer count
	typedef logic [`RST_TIMER_WIDTH-1:0] hold_count_t;

endpackage

// ==== rtl/rst_request_sync.sv ====
/*
 * Restart request source. Buttons are asynchronous and pass a
 * RST_SYNC_STAGES flop synchronizer; hard_reset_i must already be in the
 * sys_clk domain. restart_req_o is a registered level.
 */
`include "rst_ctrl_config.svh"

module rst_request_sync (
	input  logic                sys_clk,
	input  logic                trigger_reset,
	input  rst_ctrl_pkg::btn_t  btn_i,
	input  logic                hard_reset_i,
	output logic                restart_req_o
);

	// Synchronizer chain, index 0 samples the pins
	rst_ctrl_pkg::btn_t btn_sync [`RST_SYNC_STAGES];

	// All three held at once
	logic all_pressed;

	// --------------------------------------------------
	// Button synchronizer and request register
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			for (int i = 0; i < `RST_SYNC_STAGES; i++) begin
				btn_sync[i] <= '0;
			end
			restart_req_o <= 1'b0;
		end else begin
			btn_sync[0] <= btn_i;
			// Shift along the chain
			for (int i = 1; i < `RST_SYNC_STAGES; i++) begin
				btn_sync[i] <= btn_sync[i-1];
			end
			// Combined request registered once before use
			restart_req_o <= all_pressed | hard_reset_i;
		end
	end

	// --------------------------------------------------
	// Combination detect
	// --------------------------------------------------
	// Only the full three-button press counts
	// Partial presses are ignored however long they last
	assign all_pressed = &btn_sync[`RST_SYNC_STAGES-1];

endmodule

// ==== rtl/rst_hold_timer.sv ====
/*
 * Hold timer for the flash and system phases. A load of length N gives
 * done_o during the N-th cycle after the load edge. Reset loads the
 * flash hold, since hold-all always follows reset.
 */
`include "rst_ctrl_config.svh"

module rst_hold_timer (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic load_i,
	input  logic hold_sel_i,
	output logic done_o
);

	// Load values, one less than the hold length
	localparam rst_ctrl_pkg::hold_count_t flash_load =
		rst_ctrl_pkg::hold_count_t'(`RST_FLASH_HOLD_CYCLES - 1);
	localparam rst_ctrl_pkg::hold_count_t sys_load =
		rst_ctrl_pkg::hold_count_t'(`RST_SYS_HOLD_CYCLES - 1);

	rst_ctrl_pkg::hold_count_t count_q;
	// High while a hold is being timed
	logic running_q;

	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			count_q   <= flash_load;
			running_q <= 1'b1;
		end else if (load_i) begin
			// 0 picks the flash hold, 1 the system hold
			count_q   <= hold_sel_i ? sys_load : flash_load;
			running_q <= 1'b1;
		end else if (running_q) begin
			if (count_q == '0) begin
				// Expired, idle until the next load
				running_q <= 1'b0;
			end else begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// Single-cycle done on the last count
	assign done_o = running_q && (count_q == '0);

endmodule

// ==== rtl/rst_seq_fsm.sv ====
/*
 * Reset sequencer. Any restart request returns to hold-all on the next
 * edge, from any phase. Reset outputs are registered from the next
 * state and never glitch.
 */
module rst_seq_fsm (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic restart_req_i,
	input  logic hold_done_i,
	output logic timer_load_o,
	output logic hold_sel_o,
	output logic flash_rst_n_o,
	output logic sys_rst_o,
	output logic periph_rst_n_o
);

	rst_ctrl_pkg::seq_state_t state_q;
	rst_ctrl_pkg::seq_state_t state_nxt;

	// --------------------------------------------------
	// Next state
	// --------------------------------------------------
	always_comb begin
		state_nxt = state_q;
		case (state_q)
			rst_ctrl_pkg::SEQ_HOLD_ALL: begin
				// Flash hold over, free the boot flash
				if (hold_done_i) begin
					state_nxt = rst_ctrl_pkg::SEQ_FLASH_UP;
				end
			end
			rst_ctrl_pkg::SEQ_FLASH_UP: begin
				// System hold over, let the CPU fetch
				if (hold_done_i) begin
					state_nxt = rst_ctrl_pkg::SEQ_RUN;
				end
			end
			rst_ctrl_pkg::SEQ_RUN: begin
				state_nxt = rst_ctrl_pkg::SEQ_RUN;
			end
			default: begin
				state_nxt = rst_ctrl_pkg::SEQ_HOLD_ALL;
			end
		endcase
		// Restart wins over everything
		if (restart_req_i) begin
			state_nxt = rst_ctrl_pkg::SEQ_HOLD_ALL;
		end
	end

	// --------------------------------------------------
	// Timer control
	// --------------------------------------------------
	// Load on entry to a hold phase
	// A restart while already in hold-all reloads the flash hold
	assign timer_load_o = restart_req_i || (state_nxt != state_q);
	// System hold only when entering flash-up
	assign hold_sel_o = (state_nxt == rst_ctrl_pkg::SEQ_FLASH_UP);

	// --------------------------------------------------
	// State and reset outputs
	// --------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (trigger_reset) begin
			state_q        <= rst_ctrl_pkg::SEQ_HOLD_ALL;
			flash_rst_n_o  <= 1'b0;
			sys_rst_o      <= 1'b1;
			periph_rst_n_o <= 1'b0;
		end else begin
			state_q <= state_nxt;
			// Flash out of reset in flash-up and run
			flash_rst_n_o <= (state_nxt != rst_ctrl_pkg::SEQ_HOLD_ALL);
			// System and peripherals only in run
			sys_rst_o      <= (state_nxt != rst_ctrl_pkg::SEQ_RUN);
			periph_rst_n_o <= (state_nxt == rst_ctrl_pkg::SEQ_RUN);
		end
	end

endmodule

// ==== rtl/rst_ctrl_top.sv ====
/*
 * Reset controller top. trigger_reset is synchronous to sys_clk;
 * btn_i may be asynchronous. periph_rst_n_o serves audio and video-in.
 */
module rst_ctrl_top (
	input  logic               sys_clk,
	input  logic               trigger_reset,
	input  rst_ctrl_pkg::btn_t btn_i,
	input  logic               hard_reset_i,
	output logic               flash_rst_n_o,
	output logic               sys_rst_o,
	output logic               periph_rst_n_o
);

	logic restart_req;
	logic timer_load;
	logic hold_sel;
	logic hold_done;

	// Buttons and software request merged into one level
	rst_request_sync u_request_sync (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.btn_i         (btn_i),
		.hard_reset_i  (hard_reset_i),
		.restart_req_o (restart_req)
	);

	// Times both hold phases
	rst_hold_timer u_hold_timer (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.load_i        (timer_load),
		.hold_sel_i    (hold_sel),
		.done_o        (hold_done)
	);

	// Phase sequencing and reset outputs
	rst_seq_fsm u_seq_fsm (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.restart_req_i  (restart_req),
		.hold_done_i    (hold_done),
		.timer_load_o   (timer_load),
		.hold_sel_o     (hold_sel),
		.flash_rst_n_o  (flash_rst_n_o),
		.sys_rst_o      (sys_rst_o),
		.periph_rst_n_o (periph_rst_n_o)
	);

endmodule

// ==== verification/rst_ctrl_tests.svh ====
/*
 * Directed tests, included inside the testbench module body.
 * Each test expects the phase the previous one left behind.
 */
`ifndef RST_CTRL_TESTS_SVH
`define RST_CTRL_TESTS_SVH

	// --------------------------------------------------
	// Edge counting helpers
	// --------------------------------------------------
	task automatic hold_and_check(input int cycles, input rst_ctrl_pkg::seq_state_t expected);
		repeat (cycles) begin
			@(posedge sys_clk);
			@(negedge sys_clk);
			check_state("steady phase", expected);
		end
	endtask

	// Edges from the current one until the flash leaves reset
	task automatic count_to_flash_up(output int n);
		n = 0;
		do begin
			@(posedge sys_clk);
			n++;
			@(negedge sys_clk);
			if (!flash_rst_n_o) check_level("system held in flash hold", 1'b1, sys_rst_o);
		end while (!flash_rst_n_o);
		// Flash free but system still held
		check_state("flash release", rst_ctrl_pkg::SEQ_FLASH_UP);
	endtask

	task automatic count_to_sys_down(output int n);
		n = 0;
		do begin
			@(posedge sys_clk);
			n++;
			@(negedge sys_clk);
			if (sys_rst_o) check_state("system hold", rst_ctrl_pkg::SEQ_FLASH_UP);
		end while (sys_rst_o);
		check_state("system release", rst_ctrl_pkg::SEQ_RUN);
	endtask

	// Full release sequence counted from the last restart edge
	task automatic verify_release(input int flash_edges, input int tol);
		int n;
		count_to_flash_up(n);
		check_cycles("flash release edges", flash_edges, tol, n);
		count_to_sys_down(n);
		check_cycles("system release edges", `RST_SYS_HOLD_CYCLES, 0, n);
	endtask

	// One-cycle software request seen by the FSM 2 edges later
	task automatic pulse_hard_reset();
		int n;
		@(posedge sys_clk);
		hard_reset_i <= 1'b1;
		n = 0;
		do begin
			@(posedge sys_clk);
			n++;
			if (n == 1) hard_reset_i <= 1'b0;
			@(negedge sys_clk);
		end while (flash_rst_n_o && n < 8);
		check_cycles("reassert after hard_reset_i", 2, 0, n);
		check_level("sys_rst_o reasserted", 1'b1, sys_rst_o);
		check_level("periph_rst_n_o reasserted", 1'b0, periph_rst_n_o);
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	task automatic reset_release();
		test_name = "reset_release";
		trigger_reset <= 1'b1;
		repeat (3) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		@(negedge sys_clk);
		check_state("during reset", rst_ctrl_pkg::SEQ_HOLD_ALL);
		check_level("periph during reset", 1'b0, periph_rst_n_o);
		mon_en = 1'b1;
		verify_release(`RST_FLASH_HOLD_CYCLES, 0);
	endtask

	task automatic sw_restart_from_run();
		test_name = "sw_restart_from_run";
		check_state("start", rst_ctrl_pkg::SEQ_RUN);
		pulse_hard_reset();
		verify_release(`RST_FLASH_HOLD_CYCLES, 0);
	endtask

	task automatic button_combination();
		rst_ctrl_pkg::btn_t pattern;
		int n;
		test_name = "button_combination";
		// Fixed two-button presses and then random partial ones
		for (int i = 0; i < 13; i++) begin
			if (i < 3) begin
				pattern = ~(rst_ctrl_pkg::btn_t'(1) << i);
			end else begin
				pattern = rst_ctrl_pkg::btn_t'(draw_bits(3));
				if (pattern == 3'b111) pattern = 3'b110;
			end
			@(posedge sys_clk);
			btn_i <= pattern;
			hold_and_check(4 + draw_bits(3), rst_ctrl_pkg::SEQ_RUN);
		end
		@(posedge sys_clk);
		btn_i <= '0;
		hold_and_check(`RST_SYNC_STAGES + 2, rst_ctrl_pkg::SEQ_RUN);
		// Full combination through synchronizer, request register and FSM
		@(posedge sys_clk);
		btn_i <= 3'b111;
		n = 0;
		do begin
			@(posedge sys_clk);
			n++;
			@(negedge sys_clk);
		end while (flash_rst_n_o && n < 4 * `RST_SYNC_STAGES + 8);
		check_cycles("button reassert", `RST_SYNC_STAGES + 2, 0, n);
		// Nothing may release while held past a full flash hold
		hold_and_check(`RST_FLASH_HOLD_CYCLES + 16, rst_ctrl_pkg::SEQ_HOLD_ALL);
		@(posedge sys_clk);
		btn_i <= '0;
		verify_release(`RST_FLASH_HOLD_CYCLES + `RST_SYNC_STAGES + 1, `RST_SYNC_STAGES);
	endtask

	task automatic restart_in_flash_up();
		int n;
		int wait_edges;
		test_name = "restart_in_flash_up";
		pulse_hard_reset();
		count_to_flash_up(n);
		check_cycles("first flash release", `RST_FLASH_HOLD_CYCLES, 0, n);
		// Restart must land before the system hold ends
		wait_edges = 1 + draw_bits(7) % (`RST_SYS_HOLD_CYCLES - 4);
		hold_and_check(wait_edges, rst_ctrl_pkg::SEQ_FLASH_UP);
		pulse_hard_reset();
		verify_release(`RST_FLASH_HOLD_CYCLES, 0);
	endtask

`endif

// ==== verification/rst_ctrl_tb.sv ====
/*
 * Testbench top for the reset controller. Inputs change on the rising
 * edge and outputs are sampled on the falling edge. Stops at the first
 * error; the watchdog bounds the run from the configured hold lengths.
 */
`include "rst_ctrl_config.svh"

module rst_ctrl_tb;

	localparam int clk_period = 40;
	// Six full sequences plus slack for the button and partial-press phases
	localparam int watchdog_cycles =
		6 * (`RST_FLASH_HOLD_CYCLES + `RST_SYS_HOLD_CYCLES) + 1000;

	logic               sys_clk;
	logic               trigger_reset;
	rst_ctrl_pkg::btn_t btn_i;
	logic               hard_reset_i;
	logic               flash_rst_n_o;
	logic               sys_rst_o;
	logic               periph_rst_n_o;

	// Set once the outputs leave X after the first reset
	logic        mon_en = 1'b0;
	logic [31:0] lfsr_q;
	string       test_name;

	rst_ctrl_top u_rst_ctrl_top (
		.sys_clk        (sys_clk),
		.trigger_reset  (trigger_reset),
		.btn_i          (btn_i),
		.hard_reset_i   (hard_reset_i),
		.flash_rst_n_o  (flash_rst_n_o),
		.sys_rst_o      (sys_rst_o),
		.periph_rst_n_o (periph_rst_n_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(clk_period / 2) sys_clk = ~sys_clk;
	end

	// --------------------------------------------------
	// Error stop, random source, compare tasks
	// --------------------------------------------------
	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "run stopped at first error");
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// One LFSR step per bit taken
	function automatic int draw_bits(input int width);
		int value;
		value = 0;
		for (int i = 0; i < width; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			value = (value << 1) | int'(lfsr_q[0]);
		end
		return value;
	endfunction

	// Phase as seen from the pins
	function automatic rst_ctrl_pkg::seq_state_t implied_state(input logic flash_rst_n,
		input logic sys_rst);
		if (!flash_rst_n) begin
			return rst_ctrl_pkg::SEQ_HOLD_ALL;
		end else if (sys_rst) begin
			return rst_ctrl_pkg::SEQ_FLASH_UP;
		end
		return rst_ctrl_pkg::SEQ_RUN;
	endfunction

	task automatic check_level(input string label, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_with_error($sformatf("MISMATCH test=%s %s expected=%b actual=%b",
				test_name, label, expected, actual));
		end
	endtask

	task automatic check_state(input string label, input rst_ctrl_pkg::seq_state_t expected);
		rst_ctrl_pkg::seq_state_t actual;
		if ($isunknown({flash_rst_n_o, sys_rst_o})) begin
			stop_with_error($sformatf("reset outputs are unknown in test %s at %s",
				test_name, label));
		end
		actual = implied_state(flash_rst_n_o, sys_rst_o);
		if (actual != expected) begin
			stop_with_error($sformatf("MISMATCH test=%s %s expected=%s actual=%s",
				test_name, label, expected.name(), actual.name()));
		end
	endtask

	// Tolerance of 0 means an exact edge count
	task automatic check_cycles(input string label, input int expected, input int tol,
		input int actual);
		if (actual < expected - tol || actual > expected + tol) begin
			stop_with_error($sformatf("MISMATCH test=%s %s expected=%0d (+/-%0d) actual=%0d",
				test_name, label, expected, tol, actual));
		end
	endtask

	// --------------------------------------------------
	// Output consistency on every edge
	// --------------------------------------------------
	always @(negedge sys_clk) begin
		if (mon_en) begin
			check_level("periph_rst_n_o vs sys_rst_o", ~sys_rst_o, periph_rst_n_o);
			if (!sys_rst_o && !flash_rst_n_o) begin
				stop_with_error($sformatf("sys_rst_o released while flash in reset, test %s",
					test_name));
			end
		end
	end

	`include "rst_ctrl_tests.svh"

	initial begin
		#(clk_period * watchdog_cycles);
		stop_with_error("watchdog expired before the tests finished");
	end

	initial begin
		trigger_reset = 1'b1;
		btn_i         = '0;
		hard_reset_i  = 1'b0;
		lfsr_q        = 32'h696f_7862;
		test_name     = "init";
		reset_release();
		sw_restart_from_run();
		button_combination();
		restart_in_flash_up();
		$display("test passed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+rtl
+incdir+verification
rtl/rst_ctrl_pkg.sv
rtl/rst_request_sync.sv
rtl/rst_hold_timer.sv
rtl/rst_seq_fsm.sv
rtl/rst_ctrl_top.sv
verification/rst_ctrl_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the reset controller

VERILATOR ?= verilator
TOP       ?= rst_ctrl_tb
LINT_TOP  ?= rst_ctrl_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
LINTFLAGS ?= --lint-only -Wall
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed
RTL_SRCS  ?= rtl/rst_ctrl_pkg.sv rtl/rst_request_sync.sv rtl/rst_hold_timer.sv \
	rtl/rst_seq_fsm.sv rtl/rst_ctrl_top.sv

SIM  := $(BUILD_DIR)/V$(TOP)
DEPS := $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh verification/*.sv verification/*.svh)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(DEPS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -qx "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+rtl $(RTL_SRCS) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
